//--- Makefile
TOP = tb_calculator

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

obj_dir/V$(TOP): sim.f hw/*.sv testbench/*.sv
	verilator --binary --timing --assert -j 0 -f sim.f --top-module $(TOP)

# pass only when the run prints the pass line
sim: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir

//--- hw/bin_to_bcd.sv
`timescale 1ns/1ps
`default_nettype none

module bin_to_bcd (
    input  logic                                rst,
    input  logic                                clk_100hz,
    input  logic signed [calc_pkg::data_w-1:0]  result,
    input  logic                                result_evt,
    output logic [calc_pkg::bcd_w-1:0]          bcd,
    output logic                                neg,
    output logic                                bcd_done
);

    localparam int dw = calc_pkg::data_w;
    localparam int nw = calc_pkg::digit_w;

    logic [dw-1:0]                 mag;
    logic [calc_pkg::bcd_w-1:0]    bcd_adj;
    logic [4:0]                    step;
    logic                          busy;

    // add three to digits of 5 and up
    always_comb
    begin
        bcd_adj = bcd;
        for (int i = 0; i < calc_pkg::bcd_digits; i++)
            if (bcd[i*nw +: nw] >= 4'd5)
                bcd_adj[i*nw +: nw] = bcd[i*nw +: nw] + 4'd3;
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            busy     <= 1'b0;
            step     <= '0;
            bcd_done <= 1'b0;
        end
        else
        begin
            bcd_done <= busy && step == 5'd31 && !result_evt;
            if (result_evt)
            begin
                busy <= 1'b1;   // restarts a running conversion
                step <= '0;
            end
            else if (busy)
            begin
                step <= step + 5'd1;
                if (step == 5'd31)
                    busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge rst)
    begin
        if (result_evt)
        begin
            neg <= result[dw-1];
            mag <= result[dw-1] ? dw'(-result) : dw'(result);
            bcd <= '0;
        end
        else if (busy)
            {bcd, mag} <= {bcd_adj[calc_pkg::bcd_w-2:0], mag, 1'b0};  // msb first
    end

    for (genvar g = 0; g < calc_pkg::bcd_digits; g++)
    begin : g_digit_chk
        a_digit_range: assert property (@(posedge rst) disable iff (clk_100hz)
            bcd_done |-> bcd[g*nw +: nw] <= 4'd9);
    end

endmodule

`default_nettype wire

//--- hw/calc_pkg.sv
`default_nettype none

package calc_pkg;

    // datapath widths
    localparam int data_w     = 32;
    localparam int digit_w    = 4;
    localparam int bcd_digits = 10;   // enough for a 32-bit magnitude
    localparam int bcd_w      = bcd_digits * digit_w;

    // operator keys, swd2 to swd5
    typedef enum logic [1:0]
    {
        op_add,
        op_sub,
        op_mul,
        op_div
    } op_t;

    // expression entry
    typedef enum logic [1:0]
    {
        st_idle,
        st_term,     // digits of a term coming in
        st_op,       // operator taken, waiting for next term
        st_result    // equals seen
    } entry_t;

endpackage

`default_nettype wire

//--- hw/calculator.sv
`timescale 1ns/1ps
`default_nettype none

module calculator (
    input  logic                          rst,
    input  logic                          clk_100hz,
    input  logic [9:0]                    swp,
    input  logic [8:1]                    swd,
    output logic                          lcd_e,
    output logic                          lcd_rs,
    output logic                          lcd_rw,
    output logic [lcd_pkg::char_w-1:0]    lcd_data
);

    logic [calc_pkg::digit_w-1:0]        digit_val;
    logic                                digit_evt;
    logic                                neg_evt;
    logic                                op_evt;
    logic                                eq_evt;
    calc_pkg::op_t                       op_code;
    logic signed [calc_pkg::data_w-1:0]  result;
    logic                                result_evt;
    logic [calc_pkg::bcd_w-1:0]          bcd;
    logic                                neg;
    logic                                bcd_done;
    logic [lcd_pkg::line_w-1:0]          line2;

    assign lcd_e = rst;  // strobe runs with the clock

    key_scanner u_keys (
        .rst, .clk_100hz, .swp, .swd,
        .digit_val, .digit_evt, .neg_evt, .op_evt, .eq_evt, .op_code
    );

    expr_accumulator u_acc (
        .rst, .clk_100hz,
        .digit_val, .digit_evt, .neg_evt, .op_evt, .eq_evt, .op_code,
        .result, .result_evt
    );

    bin_to_bcd u_bcd (
        .rst, .clk_100hz, .result, .result_evt,
        .bcd, .neg, .bcd_done
    );

    result_formatter u_fmt (
        .rst, .clk_100hz, .bcd, .neg, .bcd_done, .line2
    );

    lcd_controller u_lcd (
        .rst, .clk_100hz, .line2, .lcd_rs, .lcd_rw, .lcd_data
    );

endmodule

`default_nettype wire

//--- hw/expr_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module expr_accumulator (
    input  logic                                rst,
    input  logic                                clk_100hz,
    input  logic [calc_pkg::digit_w-1:0]        digit_val,
    input  logic                                digit_evt,
    input  logic                                neg_evt,
    input  logic                                op_evt,
    input  logic                                eq_evt,
    input  calc_pkg::op_t                       op_code,
    output logic signed [calc_pkg::data_w-1:0]  result,
    output logic                                result_evt
);

    localparam int dw = calc_pkg::data_w;

    calc_pkg::entry_t state;
    calc_pkg::op_t    pend;
    logic [dw-1:0]        term_mag;
    logic                 term_neg;
    logic signed [dw-1:0] acc;
    logic signed [dw-1:0] term_s;
    logic signed [dw-1:0] acc_next;

    assign term_s = term_neg ? -$signed(term_mag) : $signed(term_mag);

    // left to right, wrapping
    always_comb
    begin
        case (pend)
            calc_pkg::op_add: acc_next = acc + term_s;
            calc_pkg::op_sub: acc_next = acc - term_s;
            calc_pkg::op_mul: acc_next = acc * term_s;
            default:
            begin
                if (term_s == 0)
                    acc_next = '0;  // x/0 = 0
                else
                    acc_next = acc / term_s;
            end
        endcase
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            state      <= calc_pkg::st_idle;
            pend       <= calc_pkg::op_add;
            term_mag   <= '0;
            term_neg   <= 1'b0;
            acc        <= '0;
            result     <= '0;
            result_evt <= 1'b0;
        end
        else
        begin
            result_evt <= 1'b0;
            if (digit_evt)
            begin
                if (state == calc_pkg::st_result)
                begin
                    // fresh expression, sign key may already be in
                    acc      <= '0;
                    pend     <= calc_pkg::op_add;
                    term_mag <= dw'(digit_val);
                end
                else
                    term_mag <= term_mag * dw'(10) + dw'(digit_val);
                state <= calc_pkg::st_term;
            end
            else if (neg_evt)
                term_neg <= 1'b1;
            else if (op_evt)
            begin
                acc      <= acc_next;
                pend     <= op_code;
                term_mag <= '0;
                term_neg <= 1'b0;
                state    <= calc_pkg::st_op;
            end
            else if (eq_evt)
            begin
                acc        <= acc_next;
                result     <= acc_next;
                result_evt <= 1'b1;
                pend       <= calc_pkg::op_add;  // an operator next continues from the result
                term_mag   <= '0;
                term_neg   <= 1'b0;
                state      <= calc_pkg::st_result;
            end
        end
    end

    a_state_legal: assert property (@(posedge rst) disable iff (clk_100hz)
        state inside {calc_pkg::st_idle, calc_pkg::st_term, calc_pkg::st_op,
                      calc_pkg::st_result});

endmodule

`default_nettype wire

//--- hw/key_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module key_scanner (
    input  logic                          rst,
    input  logic                          clk_100hz,
    input  logic [9:0]                    swp,
    input  logic [8:1]                    swd,
    output logic [calc_pkg::digit_w-1:0]  digit_val,
    output logic                          digit_evt,
    output logic                          neg_evt,
    output logic                          op_evt,
    output logic                          eq_evt,
    output calc_pkg::op_t                 op_code
);

    logic [9:0] swp_q;
    logic [8:1] swd_q;
    logic [3:0] lvl_next;   // {eq, op, neg, digit}
    logic [3:0] lvl;
    logic [3:0] lvl_prev;
    logic [calc_pkg::digit_w-1:0] dig_next;
    calc_pkg::op_t op_next;

    // only the highest class held counts as high
    always_comb
    begin
        lvl_next = '0;
        if (|swp_q)
            lvl_next[0] = 1'b1;
        else if (swd_q[1])
            lvl_next[1] = 1'b1;
        else if (|swd_q[5:2])
            lvl_next[2] = 1'b1;
        else if (swd_q[8])
            lvl_next[3] = 1'b1;
    end

    // swp1 wins, swp0 last
    always_comb
    begin
        dig_next = '0;
        for (int i = 9; i >= 1; i--)
            if (swp_q[i])
                dig_next = calc_pkg::digit_w'(i);
    end

    always_comb
    begin
        if (swd_q[2])
            op_next = calc_pkg::op_add;
        else if (swd_q[3])
            op_next = calc_pkg::op_sub;
        else if (swd_q[4])
            op_next = calc_pkg::op_mul;
        else
            op_next = calc_pkg::op_div;
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            swp_q    <= '0;
            swd_q    <= '0;
            lvl      <= '0;
            lvl_prev <= '0;
            {eq_evt, op_evt, neg_evt, digit_evt} <= '0;
        end
        else
        begin
            swp_q    <= swp;
            swd_q    <= swd;
            lvl      <= lvl_next;
            lvl_prev <= lvl;
            {eq_evt, op_evt, neg_evt, digit_evt} <= lvl & ~lvl_prev;  // rising edge
        end
    end

    // held with the level so they are stable while the pulse is out
    always_ff @(posedge rst)
    begin
        if (lvl_next[0])
            digit_val <= dig_next;
        if (lvl_next[2])
            op_code <= op_next;
    end

    a_one_event: assert property (@(posedge rst) disable iff (clk_100hz)
        $onehot0({digit_evt, neg_evt, op_evt, eq_evt}));

endmodule

`default_nettype wire

//--- hw/lcd_controller.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_controller (
    input  logic                          rst,
    input  logic                          clk_100hz,
    input  logic [lcd_pkg::line_w-1:0]    line2,
    output logic                          lcd_rs,
    output logic                          lcd_rw,
    output logic [lcd_pkg::char_w-1:0]    lcd_data
);

    localparam int cw = lcd_pkg::char_w;

    lcd_pkg::lcd_state_t state;
    logic [6:0] cnt;
    logic [6:0] hold;
    logic [3:0] char_idx;

    always_comb
    begin
        case (state)
            lcd_pkg::function_set,
            lcd_pkg::display_on,
            lcd_pkg::entry_mode:   hold = 7'(lcd_pkg::cmd_hold_cycles);
            lcd_pkg::line2_write:  hold = 7'(lcd_pkg::line_chars + 1);  // address + chars
            lcd_pkg::refresh_wait: hold = 7'(lcd_pkg::refresh_wait_cycles);
            default:               hold = 7'(lcd_pkg::power_wait_cycles);
        endcase
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            state <= lcd_pkg::power_wait;
            cnt   <= '0;
        end
        else if (cnt == hold - 7'd1)
        begin
            cnt <= '0;
            case (state)
                lcd_pkg::power_wait:   state <= lcd_pkg::function_set;
                lcd_pkg::function_set: state <= lcd_pkg::display_on;
                lcd_pkg::display_on:   state <= lcd_pkg::entry_mode;
                lcd_pkg::entry_mode:   state <= lcd_pkg::line2_write;
                lcd_pkg::line2_write:  state <= lcd_pkg::refresh_wait;
                lcd_pkg::refresh_wait: state <= lcd_pkg::line2_write;
                default:               state <= lcd_pkg::power_wait;
            endcase
        end
        else
            cnt <= cnt + 7'd1;
    end

    assign char_idx = 4'd0 - cnt[3:0];  // 16 - cnt, leftmost char first

    always_comb
    begin
        lcd_rs   = 1'b1;
        lcd_rw   = 1'b1;
        lcd_data = '0;
        case (state)
            lcd_pkg::function_set:
            begin
                lcd_rs   = 1'b0;
                lcd_rw   = 1'b0;
                lcd_data = lcd_pkg::cmd_function_set;
            end
            lcd_pkg::display_on:
            begin
                lcd_rs   = 1'b0;
                lcd_rw   = 1'b0;
                lcd_data = lcd_pkg::cmd_display_on;
            end
            lcd_pkg::entry_mode:
            begin
                lcd_rs   = 1'b0;
                lcd_rw   = 1'b0;
                lcd_data = lcd_pkg::cmd_entry_mode;
            end
            lcd_pkg::line2_write:
            begin
                lcd_rw = 1'b0;
                if (cnt == '0)
                begin
                    lcd_rs   = 1'b0;
                    lcd_data = lcd_pkg::cmd_line2_addr;
                end
                else
                    lcd_data = line2[char_idx*cw +: cw];
            end
            default: ;  // idle bus
        endcase
    end

    a_cmd_write: assert property (@(posedge rst) disable iff (clk_100hz)
        (state != lcd_pkg::power_wait && !lcd_rs) |-> !lcd_rw);

endmodule

`default_nettype wire

//--- hw/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

    localparam int char_w     = 8;
    localparam int line_chars = 16;
    localparam int line_w     = line_chars * char_w;

    // ascii
    localparam logic [char_w-1:0] chr_blank = 8'h20;
    localparam logic [char_w-1:0] chr_zero  = 8'h30;
    localparam logic [char_w-1:0] chr_minus = 8'h2D;

    // controller command bytes
    localparam logic [char_w-1:0] cmd_function_set = 8'h3C;  // 8 bit bus, 2 lines
    localparam logic [char_w-1:0] cmd_display_on   = 8'h0C;
    localparam logic [char_w-1:0] cmd_entry_mode   = 8'h06;
    localparam logic [char_w-1:0] cmd_line2_addr   = 8'hC0;

    typedef enum logic [2:0]
    {
        power_wait,
        function_set,
        display_on,
        entry_mode,
        line2_write,
        refresh_wait
    } lcd_state_t;

    // hold counts in clock cycles
    localparam int power_wait_cycles   = 70;
    localparam int cmd_hold_cycles     = 30;
    localparam int refresh_wait_cycles = 40;

endpackage

`default_nettype wire

//--- hw/result_formatter.sv
`timescale 1ns/1ps
`default_nettype none

module result_formatter (
    input  logic                          rst,
    input  logic                          clk_100hz,
    input  logic [calc_pkg::bcd_w-1:0]    bcd,
    input  logic                          neg,
    input  logic                          bcd_done,
    output logic [lcd_pkg::line_w-1:0]    line2
);

    localparam int cw = lcd_pkg::char_w;

    logic [3:0] pos;
    logic [3:0] cur;
    logic [3:0] msd;         // leftmost digit shown
    logic [3:0] sign_pos;
    logic [calc_pkg::digit_w-1:0] digit;
    logic active;
    logic place_sign;
    logic lead;
    logic lead_now;
    logic blank_it;

    // char index 0 is the rightmost on the display
    assign cur      = bcd_done ? 4'd9 : pos;
    assign digit    = bcd[cur*calc_pkg::digit_w +: calc_pkg::digit_w];
    assign lead_now = bcd_done | lead;
    assign blank_it = lead_now && digit == '0 && cur != 4'd0;  // last digit always shown
    assign sign_pos = msd + 4'd1;

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            line2      <= {lcd_pkg::line_chars{lcd_pkg::chr_blank}};
            pos        <= '0;
            msd        <= '0;
            active     <= 1'b0;
            place_sign <= 1'b0;
            lead       <= 1'b1;
        end
        else
        begin
            place_sign <= 1'b0;
            if (bcd_done || active)
            begin
                if (bcd_done)
                    line2[lcd_pkg::line_w-1:10*cw] <= {6{lcd_pkg::chr_blank}};
                line2[cur*cw +: cw] <= blank_it ? lcd_pkg::chr_blank
                                                : lcd_pkg::chr_zero + cw'(digit);
                if (lead_now && !blank_it)
                    msd <= cur;
                lead       <= blank_it;
                pos        <= cur - 4'd1;
                active     <= cur != 4'd0;
                place_sign <= cur == 4'd0;
            end
            else if (place_sign && neg)
                line2[sign_pos*cw +: cw] <= lcd_pkg::chr_minus;
        end
    end

endmodule

`default_nettype wire

//--- sim.f
hw/calc_pkg.sv
hw/lcd_pkg.sv
hw/key_scanner.sv
hw/expr_accumulator.sv
hw/bin_to_bcd.sv
hw/result_formatter.sv
hw/lcd_controller.sv
hw/calculator.sv
testbench/tb_calculator.sv

//--- testbench/tb_calculator.sv
`timescale 1ns/1ps
`default_nettype none

module tb_calculator;

    // 379 key presses and 29 equals presses in all, doubled
    localparam int max_cycles = 2 * (160 + 40 * 379 + 120 * 29);

    logic       rst;
    logic       clk_100hz;
    logic [9:0] swp;
    logic [8:1] swd;
    logic       lcd_e;
    logic       lcd_rs;
    logic       lcd_rw;
    logic [7:0] lcd_data;

    int           cycle;
    int           tests_run;
    int           tests_failed;
    int           strobe_errs;
    integer       seed;
    logic [7:0]   cmd_log[$];
    logic [127:0] burst_lines[$];   // leftmost char in the top byte
    int           burst_starts[$];
    logic         in_burst;
    int           nchar;
    int           cur_start;
    logic [127:0] cur_line;
    logic         prev_cmd;
    logic [7:0]   prev_data;

    calculator uut (
        .rst, .clk_100hz, .swp, .swd, .lcd_e, .lcd_rs, .lcd_rw, .lcd_data
    );

    always #2 rst = ~rst;

    always @(posedge rst)
    begin
        cycle = cycle + 1;
        if (cycle >= max_cycles)
        begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // strobe follows the clock, looked at away from the edges
    always @(posedge rst or negedge rst)
    begin
        #1;
        assert (lcd_e === rst)
        else
        begin
            $display("ERR lcd_e expected %h got %h", rst, lcd_e);
            strobe_errs++;
        end
    end

    // bus sampled mid-cycle
    always @(negedge rst)
    begin
        if (!lcd_rs && !lcd_rw)
        begin
            if (!prev_cmd || lcd_data != prev_data)
            begin
                if (cmd_log.size() < 8)
                    cmd_log.push_back(lcd_data);
                if (lcd_data == lcd_pkg::cmd_line2_addr)
                begin
                    in_burst  = 1'b1;
                    nchar     = 0;
                    cur_start = cycle;
                end
            end
        end
        else if (in_burst && lcd_rs && !lcd_rw)
        begin
            cur_line = {cur_line[119:0], lcd_data};
            nchar++;
            if (nchar == 16)
            begin
                burst_lines.push_back(cur_line);
                burst_starts.push_back(cur_start);
                in_burst = 1'b0;
            end
        end
        else
            in_burst = 1'b0;
        prev_cmd  = !lcd_rs && !lcd_rw;
        prev_data = lcd_data;
    end

    // left to right step, wrapping, x/0 = 0
    function automatic logic signed [31:0] apply_op(input logic signed [31:0] a,
                                                    input logic signed [31:0] b,
                                                    input calc_pkg::op_t op);
        logic [31:0] ua;
        logic [31:0] ub;
        logic [31:0] q;
        ua = a[31] ? -a : a;
        ub = b[31] ? -b : b;
        case (op)
            calc_pkg::op_add: return a + b;
            calc_pkg::op_sub: return a - b;
            calc_pkg::op_mul: return a * b;
            default:
            begin
                if (b == 0)
                    return '0;
                q = ua / ub;   // truncates toward zero
                return (a[31] ^ b[31]) ? -q : q;
            end
        endcase
    endfunction

    function automatic logic [127:0] expected_line(input logic signed [31:0] v);
        logic [127:0] line;
        logic [31:0]  mag;
        int           pos;
        line = {16{lcd_pkg::chr_blank}};
        mag  = v[31] ? -v : v;
        pos  = 15;
        do
        begin
            line[(15 - pos) * 8 +: 8] = lcd_pkg::chr_zero + 8'(mag % 32'd10);
            mag = mag / 32'd10;
            pos--;
        end
        while (mag != 0);
        if (v[31])
            line[(15 - pos) * 8 +: 8] = lcd_pkg::chr_minus;
        return line;
    endfunction

    function automatic int compare_line(input logic [127:0] exp_line,
                                        input logic [127:0] got_line);
        int         errs;
        logic [7:0] e;
        logic [7:0] g;
        errs = 0;
        for (int i = 0; i < 16; i++)
        begin
            e = exp_line[(15 - i) * 8 +: 8];
            g = got_line[(15 - i) * 8 +: 8];
            assert (g == e)
            else
            begin
                $display("ERR line2[%0d] expected %h got %h", i, e, g);
                errs++;
            end
        end
        return errs;
    endfunction

    task automatic report_test(input string name, input int errs);
        tests_run++;
        if (errs != 0)
            tests_failed++;
        $display("%s: %s, %0d mismatches", name, errs == 0 ? "pass" : "fail", errs);
    endtask

    task automatic press_key(input logic [9:0] p, input logic [8:1] d, input int hold);
        swp = p;
        swd = d;
        repeat (hold) @(negedge rst);
        swp = '0;
        swd = '0;
        repeat (3) @(negedge rst);
    endtask

    task automatic type_term(input int mag, input bit negative);
        int digits[10];
        int n;
        n = 0;
        if (negative)
            press_key('0, 8'b0000_0001, 3);   // swd1
        do
        begin
            digits[n] = mag % 10;
            mag = mag / 10;
            n++;
        end
        while (mag != 0);
        for (int i = n - 1; i >= 0; i--)
            press_key(10'(1) << digits[i], '0, 3);
    endtask

    task automatic press_op(input calc_pkg::op_t op);
        press_key('0, 8'(1) << (int'(op) + 1), 3);   // swd2 to swd5
    endtask

    // second burst that starts after the equals press
    task automatic check_result(input string name, input logic signed [31:0] value);
        logic [127:0] exp_line;
        int           eq_cycle;
        int           idx;
        int           seen;
        exp_line = expected_line(value);
        eq_cycle = cycle;
        press_key('0, 8'h80, 3);
        idx  = 0;
        seen = 0;
        while (seen < 2)
        begin
            if (idx < burst_lines.size())
            begin
                if (burst_starts[idx] > eq_cycle)
                    seen++;
                idx++;
            end
            else
                @(negedge rst);
        end
        report_test(name, compare_line(exp_line, burst_lines[idx - 1]));
    endtask

    task automatic check_power_up();
        logic [7:0] want[3];
        int         errs;
        want = '{lcd_pkg::cmd_function_set, lcd_pkg::cmd_display_on,
                 lcd_pkg::cmd_entry_mode};
        errs = 0;
        while (burst_lines.size() < 1)
            @(negedge rst);
        for (int i = 0; i < 3; i++)
        begin
            assert (cmd_log[i] == want[i])
            else
            begin
                $display("ERR lcd_data cmd %0d expected %h got %h", i, want[i], cmd_log[i]);
                errs++;
            end
        end
        errs += compare_line({16{lcd_pkg::chr_blank}}, burst_lines[0]);
        report_test("power-up", errs);
    endtask

    task automatic run_random_chain(input int n);
        int                 mag[3];
        bit                 negs[3];
        calc_pkg::op_t      ops[3];
        logic signed [31:0] acc;
        int                 ndig;
        ops[0] = calc_pkg::op_add;   // accumulator starts with a pending add
        for (int t = 0; t < 3; t++)
        begin
            ndig    = 1 + int'($unsigned($random(seed)) % 4);
            mag[t]  = int'($unsigned($random(seed)) % (10 ** ndig));
            negs[t] = ($random(seed) % 2) != 0;
        end
        ops[1] = calc_pkg::op_t'(2'($random(seed)));
        ops[2] = calc_pkg::op_t'(2'($random(seed)));
        acc = '0;
        for (int t = 0; t < 3; t++)
        begin
            type_term(mag[t], negs[t]);
            if (t < 2)
                press_op(ops[t + 1]);
            acc = apply_op(acc, negs[t] ? -mag[t] : mag[t], ops[t]);
        end
        check_result($sformatf("random chain %0d", n), acc);
    endtask

    initial
    begin
        rst         = 1'b0;
        clk_100hz   = 1'b1;
        swp         = '0;
        swd         = '0;
        seed        = 32'h2037a20a;
        strobe_errs = 0;
        in_burst    = 1'b0;
        prev_cmd    = 1'b0;
        prev_data   = '0;
        cur_line    = '0;
        repeat (4) @(posedge rst);
        @(negedge rst);
        clk_100hz = 1'b0;

        check_power_up();

        type_term(12, 0);
        press_op(calc_pkg::op_add);
        type_term(34, 0);
        check_result("add 12+34", apply_op(12, 34, calc_pkg::op_add));

        type_term(5, 0);
        press_op(calc_pkg::op_sub);
        type_term(9, 0);
        check_result("sub 5-9", apply_op(5, 9, calc_pkg::op_sub));

        type_term(7, 1);
        press_op(calc_pkg::op_mul);
        type_term(6, 0);
        check_result("mul -7*6", apply_op(-7, 6, calc_pkg::op_mul));

        type_term(17, 0);
        press_op(calc_pkg::op_div);
        type_term(5, 1);
        check_result("div 17/-5", apply_op(17, -5, calc_pkg::op_div));

        type_term(9, 0);
        press_op(calc_pkg::op_div);
        type_term(0, 0);
        check_result("div 9/0", apply_op(9, 0, calc_pkg::op_div));

        type_term(0, 0);
        check_result("zero", apply_op(0, 0, calc_pkg::op_add));

        // product wraps past 2^31
        type_term(9999, 0);
        press_op(calc_pkg::op_mul);
        type_term(9999, 0);
        press_op(calc_pkg::op_mul);
        type_term(9999, 0);
        check_result("mul wrap", apply_op(apply_op(9999, 9999, calc_pkg::op_mul), 9999,
                                          calc_pkg::op_mul));

        for (int n = 0; n < 20; n++)
            run_random_chain(n);

        press_key(10'(1) << 7, '0, 20);   // long hold, one digit
        check_result("held key", apply_op(0, 7, calc_pkg::op_add));
        type_term(3, 0);
        press_op(calc_pkg::op_add);
        type_term(1, 0);
        check_result("new expression", apply_op(3, 1, calc_pkg::op_add));

        report_test("lcd strobe", strobe_errs);

        $display("tests run %0d, failed %0d", tests_run, tests_failed);
        if (tests_failed == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
